// ==== rtl/fp_add_unit.sv ====
`timescale 1ns/1ps

module fp_add_unit
   import fp_pkg::*;
(
   input  logic         clk,
   input  logic         arst_n,
   input  logic         start,
   input  fp_operands_t operands,
   output fp_word_t     value,
   output logic         ready
);

   localparam int SUM_W = MANT_W + 2;   // sign, carry, mantissa.

   typedef enum logic [2:0] {
      st_idle,
      st_align,
      st_sign,
      st_sum,
      st_norm
   } add_state_e;

   add_state_e state;

   fp_operands_t            op_q;
   logic signed [SUM_W-1:0] aligned_a;
   logic signed [SUM_W-1:0] aligned_b;
   logic signed [SUM_W-1:0] sum;
   logic signed [SUM_W-1:0] neg_sum;
   logic [MANT_W:0]         mag;
   fp_exp_t                 exp_r;
   logic                    sum_sign;
   logic                    sign_r;
   logic                    norm_done;

   logic     sign_a;
   logic     sign_b;
   fp_exp_t  exp_a;
   fp_exp_t  exp_b;
   fp_mant_t mant_a;
   fp_mant_t mant_b;

   assign sign_a = fp_sign_of(op_q.a);
   assign sign_b = fp_sign_of(op_q.b);
   assign exp_a  = fp_exp_of(op_q.a);
   assign exp_b  = fp_exp_of(op_q.b);
   assign mant_a = fp_mant_of(op_q.a);
   assign mant_b = fp_mant_of(op_q.b);

   assign sum     = aligned_a + aligned_b;
   assign neg_sum = -sum;

   // carry out, hidden bit in place, or nothing left to shift.
   assign norm_done = mag[MANT_W] | mag[MANT_W-1] | (mag == '0);

   // ***********************************************************
   // sequencing
   // ***********************************************************

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state <= st_idle;
      end else begin
         case (state)
            st_idle:  if (start) state <= st_align;
            st_align: state <= st_sign;
            st_sign:  state <= st_sum;
            st_sum:   state <= st_norm;
            st_norm:  if (norm_done) state <= st_idle;
            default:  state <= st_idle;
         endcase
      end
   end

   // ***********************************************************
   // datapath
   // ***********************************************************

   always_ff @(posedge clk) begin
      case (state)
         st_idle: begin
            if (start) op_q <= operands;
         end
         st_align: begin
            // the smaller operand slides right, the larger exponent stays.
            if (exp_a >= exp_b) begin
               aligned_a <= {2'b00, mant_a};
               aligned_b <= {2'b00, mant_b >> (exp_a - exp_b)};
               exp_r     <= exp_a;
            end else begin
               aligned_a <= {2'b00, mant_a >> (exp_b - exp_a)};
               aligned_b <= {2'b00, mant_b};
               exp_r     <= exp_b;
            end
         end
         st_sign: begin
            if (sign_a == sign_b) begin
               sum_sign <= sign_a;
            end else begin
               sum_sign <= 1'b0;   // sign of the sum decides.
               if (sign_a) begin
                  aligned_a <= -aligned_a;
               end else begin
                  aligned_b <= -aligned_b;
               end
            end
         end
         st_sum: begin
            if (sum[SUM_W-1]) begin
               sign_r <= 1'b1;
               mag    <= neg_sum[MANT_W:0];
            end else begin
               sign_r <= sum_sign;
               mag    <= sum[MANT_W:0];
            end
         end
         st_norm: begin
            if (mag[MANT_W]) begin
               mag   <= {1'b0, mag[MANT_W:1]};
               exp_r <= exp_r + 1'b1;
            end else if (!mag[MANT_W-1]) begin
               if (mag == '0) begin
                  exp_r  <= '0;   // positive zero.
                  sign_r <= 1'b0;
               end else begin
                  mag   <= {mag[MANT_W-1:0], 1'b0};
                  exp_r <= exp_r - 1'b1;
               end
            end
         end
         default: ;
      endcase
   end

   assign value = {sign_r, exp_r, mag[FRAC_W-1:0]};
   assign ready = (state == st_idle);

endmodule

// ==== rtl/fp_arith_top.sv ====
`timescale 1ns/1ps

module fp_arith_top
   import fp_pkg::*;
(
   input  logic         clk,
   input  logic         arst_n,
   input  logic         start,
   input  fp_op_e       op,
   input  fp_operands_t operands,
   output fp_word_t     result,
   output logic         done,
   output logic         busy
);

   logic         add_start;
   logic         mul_start;
   fp_operands_t unit_operands;
   fp_word_t     add_value;
   logic         add_ready;
   fp_word_t     mul_value;
   logic         mul_ready;

   fp_op_sequencer fp_op_sequencer_inst (
      .clk           (clk),
      .arst_n        (arst_n),
      .start         (start),
      .op            (op),
      .operands      (operands),
      .add_value     (add_value),
      .add_ready     (add_ready),
      .mul_value     (mul_value),
      .mul_ready     (mul_ready),
      .add_start     (add_start),
      .mul_start     (mul_start),
      .unit_operands (unit_operands),
      .result        (result),
      .done          (done),
      .busy          (busy)
   );

   fp_add_unit fp_add_unit_inst (
      .clk      (clk),
      .arst_n   (arst_n),
      .start    (add_start),
      .operands (unit_operands),
      .value    (add_value),
      .ready    (add_ready)
   );

   fp_mul_unit #(
      .MANT_W (fp_pkg::MANT_W)
   ) fp_mul_unit_inst (
      .clk      (clk),
      .arst_n   (arst_n),
      .start    (mul_start),
      .operands (unit_operands),
      .value    (mul_value),
      .ready    (mul_ready)
   );

endmodule

// ==== rtl/fp_mul_unit.sv ====
`timescale 1ns/1ps

module fp_mul_unit
   import fp_pkg::*;
#(
   parameter int MANT_W = fp_pkg::MANT_W
)
(
   input  logic         clk,
   input  logic         arst_n,
   input  logic         start,
   input  fp_operands_t operands,
   output fp_word_t     value,
   output logic         ready
);

   localparam int EXP_SUM_W = EXP_W + 2;   // room for the sum of two exponents.

   typedef enum logic [1:0] {
      st_idle,
      st_smult,
      st_mult,
      st_norm
   } mul_state_e;

   mul_state_e state;

   fp_operands_t          op_q;
   logic                  sign_r;
   logic [EXP_SUM_W-1:0]  exp_sum;
   logic [2*MANT_W-1:0]   product;
   logic [2*MANT_W-1:0]   mant_product;
   logic                  mant_start;
   logic                  mant_ready;

   assign mant_start = (state == st_smult);

   mant_mul_shift_add #(
      .MANT_W (MANT_W)
   ) mant_mul_shift_add_inst (
      .clk     (clk),
      .arst_n  (arst_n),
      .start   (mant_start),
      .a       (fp_mant_of(op_q.a)),
      .b       (fp_mant_of(op_q.b)),
      .product (mant_product),
      .ready   (mant_ready)
   );

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state <= st_idle;
      end else begin
         case (state)
            st_idle:  if (start) state <= st_smult;
            st_smult: state <= st_mult;
            st_mult:  if (mant_ready) state <= st_norm;
            st_norm:  state <= st_idle;
            default:  state <= st_idle;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      case (state)
         st_idle: begin
            if (start) op_q <= operands;
         end
         st_smult: begin
            sign_r  <= fp_sign_of(op_q.a) ^ fp_sign_of(op_q.b);
            exp_sum <= EXP_SUM_W'(fp_exp_of(op_q.a)) + EXP_SUM_W'(fp_exp_of(op_q.b));
         end
         st_mult: begin
            if (mant_ready) begin
               product <= mant_product;
               exp_sum <= exp_sum - EXP_SUM_W'(EXP_BIAS - 1);   // product top bit is 2^1.
            end
         end
         st_norm: begin
            if (!product[2*MANT_W-1]) begin
               if (product == '0) begin
                  exp_sum <= '0;
                  sign_r  <= 1'b0;
               end else begin
                  product <= {product[2*MANT_W-2:0], 1'b0};
                  exp_sum <= exp_sum - 1'b1;
               end
            end
         end
         default: ;
      endcase
   end

   assign value = {sign_r, exp_sum[EXP_W-1:0], product[2*MANT_W-2 -: FRAC_W]};
   assign ready = (state == st_idle);

endmodule

// ==== rtl/fp_op_sequencer.sv ====
`timescale 1ns/1ps

module fp_op_sequencer
   import fp_pkg::*;
(
   input  logic         clk,
   input  logic         arst_n,
   input  logic         start,
   input  fp_op_e       op,
   input  fp_operands_t operands,
   input  fp_word_t     add_value,
   input  logic         add_ready,
   input  fp_word_t     mul_value,
   input  logic         mul_ready,
   output logic         add_start,
   output logic         mul_start,
   output fp_operands_t unit_operands,
   output fp_word_t     result,
   output logic         done,
   output logic         busy
);

   typedef enum logic [1:0] {
      st_idle,
      st_launch,
      st_wait,
      st_deliver
   } seq_state_e;

   seq_state_e   state;
   fp_op_e       op_q;
   logic         accept;
   logic         use_mul;
   logic         unit_ready;
   fp_word_t     unit_value;
   fp_operands_t routed;

   assign accept     = start && (state == st_idle);   // starts while busy are dropped.
   assign use_mul    = (op_q == op_mul);
   assign unit_ready = use_mul ? mul_ready : add_ready;
   assign unit_value = use_mul ? mul_value : add_value;

   // subtract is an add with b negated.
   always_comb begin
      routed = operands;
      if (op == op_sub) begin
         routed.b[FP_W-1] = ~operands.b[FP_W-1];
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state     <= st_idle;
         op_q      <= op_add;
         add_start <= 1'b0;
         mul_start <= 1'b0;
         done      <= 1'b0;
         result    <= '0;
      end else begin
         done <= 1'b0;
         case (state)
            st_idle: begin
               if (accept) begin
                  op_q      <= op;
                  add_start <= (op != op_mul);
                  mul_start <= (op == op_mul);
                  state     <= st_launch;
               end
            end
            st_launch: begin
               add_start <= 1'b0;
               mul_start <= 1'b0;
               state     <= st_wait;
            end
            st_wait: begin
               if (unit_ready) state <= st_deliver;
            end
            st_deliver: begin
               result <= unit_value;
               done   <= 1'b1;
               state  <= st_idle;
            end
            default: state <= st_idle;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (accept) unit_operands <= routed;
   end

   assign busy = (state != st_idle);

endmodule

// ==== rtl/fp_pkg.sv ====
package fp_pkg;

   // binary32 field layout.
   localparam int EXP_W    = 8;
   localparam int FRAC_W   = 23;
   localparam int FP_W     = 32;
   localparam int EXP_BIAS = 127;
   localparam int MANT_W   = FRAC_W + 1;   // fraction plus hidden one.

   typedef logic [FP_W-1:0]   fp_word_t;
   typedef logic [EXP_W-1:0]  fp_exp_t;
   typedef logic [MANT_W-1:0] fp_mant_t;

   typedef enum logic [1:0] {
      op_add,
      op_sub,
      op_mul
   } fp_op_e;

   typedef struct packed {
      fp_word_t a;
      fp_word_t b;
   } fp_operands_t;

   // biased exponent field of a word.
   function automatic fp_exp_t fp_exp_of(input fp_word_t w);
      return w[FP_W-2 -: EXP_W];
   endfunction

   // mantissa with the hidden bit; a zero exponent reads as zero.
   function automatic fp_mant_t fp_mant_of(input fp_word_t w);
      fp_mant_t m;
      if (w[FP_W-2 -: EXP_W] == '0) begin
         m = '0;
      end else begin
         m = {1'b1, w[FRAC_W-1:0]};
      end
      return m;
   endfunction

   function automatic logic fp_sign_of(input fp_word_t w);
      return w[FP_W-1];
   endfunction

endpackage

// ==== rtl/mant_mul_shift_add.sv ====
`timescale 1ns/1ps

module mant_mul_shift_add
   import fp_pkg::*;
#(
   parameter int MANT_W = fp_pkg::MANT_W
)
(
   input  logic                clk,
   input  logic                arst_n,
   input  logic                start,
   input  fp_mant_t            a,
   input  fp_mant_t            b,
   output logic [2*MANT_W-1:0] product,
   output logic                ready
);

   logic [MANT_W:0]     step;   // one-hot, top bit means finished.
   logic [MANT_W-1:0]   a_q;
   logic [MANT_W-1:0]   b_q;
   logic [2*MANT_W-1:0] acc;
   logic [2*MANT_W-1:0] addend;

   assign addend = b_q[MANT_W-1] ? {{MANT_W{1'b0}}, a_q} : '0;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         step <= {1'b1, {MANT_W{1'b0}}};
      end else if (start) begin
         step <= {{MANT_W{1'b0}}, 1'b1};
      end else if (!ready) begin
         step <= step << 1;
      end
   end

   // msb of b first: double, then add a.
   always_ff @(posedge clk) begin
      if (start) begin
         acc <= '0;
         a_q <= a;
         b_q <= b;
      end else if (!ready) begin
         acc <= {acc[2*MANT_W-2:0], 1'b0} + addend;
         b_q <= b_q << 1;
      end
   end

   assign product = acc;
   assign ready   = step[MANT_W];

endmodule

// ==== tb.f ====
+incdir+tb
rtl/fp_pkg.sv
rtl/mant_mul_shift_add.sv
rtl/fp_add_unit.sv
rtl/fp_mul_unit.sv
rtl/fp_op_sequencer.sv
rtl/fp_arith_top.sv
tb/fp_arith_tb.sv

// ==== tb/fp_arith_vectors.svh ====
`ifndef FP_ARITH_VECTORS_SVH
`define FP_ARITH_VECTORS_SVH

// columns: operation, a, b, expected result, and a flag that pulses
// extra starts with random values while the unit is busy.
typedef struct packed {
   fp_op_e   op;
   fp_word_t a;
   fp_word_t b;
   fp_word_t expected;
   logic     poke;
} vector_t;

localparam int NUM_VECTORS = 19;

localparam vector_t VECTORS [NUM_VECTORS] = '{
   '{op_add, 32'h3fc0_0000, 32'h4010_0000, 32'h4070_0000, 1'b0},   // 1.5 + 2.25.
   '{op_add, 32'h4000_0000, 32'hbf00_0000, 32'h3fc0_0000, 1'b0},   // 2.0 + -0.5.
   '{op_add, 32'h3fc0_0000, 32'h3fc0_0000, 32'h4040_0000, 1'b0},   // carry out.
   '{op_add, 32'h3f80_0000, 32'hbf70_0000, 32'h3d80_0000, 1'b0},   // four left shifts.
   '{op_add, 32'hc040_0000, 32'h3f80_0000, 32'hc000_0000, 1'b0},   // negative sum.
   '{op_add, 32'h0000_0000, 32'h4020_0000, 32'h4020_0000, 1'b0},   // 0 + 2.5.
   // subtraction.
   '{op_sub, 32'h3f80_0000, 32'h3e80_0000, 32'h3f40_0000, 1'b0},   // 1.0 - 0.25.
   '{op_sub, 32'h40a0_0000, 32'h40a0_0000, 32'h0000_0000, 1'b0},   // equal operands.
   '{op_sub, 32'h3f80_0000, 32'h4040_0000, 32'hc000_0000, 1'b0},   // 1.0 - 3.0.
   '{op_sub, 32'hbfc0_0000, 32'hc010_0000, 32'h3f40_0000, 1'b0},   // -1.5 - -2.25.
   // multiplication.
   '{op_mul, 32'h4040_0000, 32'h4020_0000, 32'h40f0_0000, 1'b0},   // 3.0 * 2.5.
   '{op_mul, 32'hbfc0_0000, 32'h4080_0000, 32'hc0c0_0000, 1'b0},   // -1.5 * 4.0.
   '{op_mul, 32'h3fc0_0000, 32'h3fc0_0000, 32'h4010_0000, 1'b0},   // product top bit set.
   '{op_mul, 32'h0000_0000, 32'h4040_0000, 32'h0000_0000, 1'b0},
   '{op_mul, 32'hc000_0000, 32'h0000_0000, 32'h0000_0000, 1'b0},   // zero stays positive.
   '{op_mul, 32'hbf00_0000, 32'hbf00_0000, 32'h3e80_0000, 1'b0},   // -0.5 * -0.5.
   // starts while busy must be dropped.
   '{op_add, 32'h3fc0_0000, 32'h4010_0000, 32'h4070_0000, 1'b1},
   '{op_mul, 32'h4000_0000, 32'h3f00_0000, 32'h3f80_0000, 1'b1},
   '{op_sub, 32'h3f80_0000, 32'h3e80_0000, 32'h3f40_0000, 1'b1}
};

`endif

// ==== tb/fp_arith_tb.sv ====
`timescale 1ns/1ps

module fp_arith_tb
   import fp_pkg::*;
();

   `include "fp_arith_vectors.svh"

   localparam int CLK_PERIOD      = 100;
   localparam int WATCHDOG_CYCLES = (NUM_VECTORS + 2) * 80;

   logic         clk = 1'b0;
   logic         arst_n;
   logic         start;
   fp_op_e       op;
   fp_operands_t operands;
   fp_word_t     result;
   logic         done;
   logic         busy;

   integer seed       = 32'h02b2_0420;
   int     done_count = 0;

   fp_arith_top fp_arith_top_inst (
      .clk      (clk),
      .arst_n   (arst_n),
      .start    (start),
      .op       (op),
      .operands (operands),
      .result   (result),
      .done     (done),
      .busy     (busy)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   // every done pulse, wanted or not.
   always @(negedge clk) begin
      if (done) done_count <= done_count + 1;
   end

   task automatic compare(input string name, input logic [FP_W-1:0] actual,
                          input logic [FP_W-1:0] expected);
      if (actual !== expected) begin
         $display("MISMATCH at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
         $display("tests failed");
         $fatal(1, "stopping at the first wrong value");
      end
   endtask

   initial begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      $display("watchdog expired: done never came for the request in flight");
      $display("tests failed");
      $fatal(1, "run ended by the watchdog");
   end

   // ***********************************************************
   // stimulus
   // ***********************************************************

   initial begin
      vector_t  vec;
      int       gap;
      fp_word_t held;

      arst_n   = 1'b0;
      start    = 1'b0;
      op       = op_add;
      operands = '0;
      repeat (2) @(posedge clk);
      @(negedge clk);
      arst_n = 1'b1;
      @(negedge clk);
      compare("done", done, 1'b0);
      compare("busy", busy, 1'b0);
      compare("result", result, '0);
      held = '0;

      for (int i = 0; i < NUM_VECTORS; i++) begin
         vec = VECTORS[i];
         compare("done_count", done_count, i);   // one done per request so far.
         compare("busy", busy, 1'b0);
         op         = vec.op;
         operands.a = vec.a;
         operands.b = vec.b;
         start      = 1'b1;
         @(negedge clk);
         start = 1'b0;
         while (!done) begin
            compare("busy", busy, 1'b1);
            compare("result", result, held);   // old value until done.
            if (vec.poke) begin
               start      = 1'b1;   // lands on a busy unit.
               op         = fp_op_e'($unsigned($random(seed)) % 3);
               operands.a = $random(seed);
               operands.b = $random(seed);
            end
            @(negedge clk);
         end
         start = 1'b0;
         compare("busy", busy, 1'b0);
         compare("result", result, vec.expected);
         held = vec.expected;
         @(negedge clk);
         compare("done", done, 1'b0);   // pulse is one cycle wide.

         // result must hold through the idle gap.
         gap = $unsigned($random(seed)) % 4;
         repeat (gap) begin
            compare("result", result, vec.expected);
            @(negedge clk);
         end
         compare("result", result, vec.expected);
      end

      repeat (4) @(negedge clk);
      compare("done_count", done_count, NUM_VECTORS);
      compare("busy", busy, 1'b0);
      $display("all tests passed");
      $finish;
   end

endmodule
